// ==== hdl/icachePkg.sv ====
package icachePkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////

    localparam int numLines = 8;
    localparam int numWays = 2;
    localparam int numSets = numLines / numWays;
    localparam int lineBytesLog = 4;   // 16-byte lines.
    localparam int wordsPerLine = 4;

    ////////////////////////////////////////
    // derived widths
    ////////////////////////////////////////

    localparam int setBits = $clog2(numSets);
    localparam int wayBits = $clog2(numWays);
    localparam int wordSelBits = $clog2(wordsPerLine);

    // tag is what is left of a 32-bit byte address above the set index.
    localparam int tagBits = 32 - lineBytesLog - setBits;

    // data RAM words are addressed as {way, set, word}.
    localparam int sramAddrBits = wayBits + setBits + wordSelBits;
    localparam int extAddrBits = 30;   // external memory is word addressed.

    // command from the tag table to the line-fill controller.
    typedef enum logic [0:0] {
        FILL_NONE = 1'b0,
        FILL_LINE = 1'b1
    } fillCmd_t;

endpackage

// ==== hdl/icacheData.sv ====
`timescale 1ns/10ps

module icacheData (
    input  logic                                  clk,
    input  logic                                  rdEn,
    input  logic [icachePkg::sramAddrBits-1:0]    rdAddr,
    output logic [31:0]                           rdData,
    input  logic                                  wrEn,
    input  logic [icachePkg::sramAddrBits-1:0]    wrAddr,
    input  logic [31:0]                           wrData
);
    import icachePkg::*;

    logic [31:0] mem [2**sramAddrBits];

    // read data holds its value between fetches.
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

endmodule

// ==== hdl/icacheTags.sv ====
`timescale 1ns/10ps

module icacheTags (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  lookupValid,
    input  logic [31:0]                           lookupPc,
    output logic [icachePkg::sramAddrBits-1:0]    lookupAddr,
    output logic                                  stall,
    output icachePkg::fillCmd_t                   fillCmd,
    output logic [icachePkg::sramAddrBits-1:0]    fillSramAddr,
    output logic [icachePkg::extAddrBits-1:0]     fillExtAddr,
    input  logic                                  fillBusy
);
    import icachePkg::*;

    typedef enum logic [1:0] {
        flushWait,
        idle,
        loadRequest,
        loadActive
    } state_t;

    state_t state;

    logic [tagBits-1:0] tagMem [numSets][numWays];
    logic               validBits [numSets][numWays];
    logic [wayBits-1:0] victim [numSets];   // next way to replace in each set.

    logic [setBits-1:0]     lookupSet;
    logic [tagBits-1:0]     lookupTag;
    logic [wordSelBits-1:0] lookupWord;
    logic                   hit;
    logic [wayBits-1:0]     hitWay;
    logic                   missStart;

    logic [setBits-1:0] loadSet;
    logic [wayBits-1:0] loadWay;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign lookupSet = lookupPc[lineBytesLog +: setBits];
    assign lookupTag = lookupPc[31 -: tagBits];
    assign lookupWord = lookupPc[2 +: wordSelBits];

    always_comb begin
        hit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (validBits[lookupSet][w] && tagMem[lookupSet][w] == lookupTag) begin
                hit = 1'b1;
                hitWay = wayBits'(w);
            end
        end
    end

    assign lookupAddr = {hitWay, lookupSet, lookupWord};

    // fetch cannot proceed while a line is being loaded.
    assign stall = (lookupValid && !hit) || (state != idle);
    assign missStart = lookupValid && !hit && (state == idle);

    ////////////////////////////////////////
    // miss handling
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= flushWait;
            fillCmd <= FILL_NONE;
            for (int s = 0; s < numSets; s++) begin
                victim[s] <= '0;
                for (int w = 0; w < numWays; w++) begin
                    validBits[s][w] <= 1'b0;
                end
            end
        end else begin
            // a hit on the pointed-to way moves the pointer on to the other one.
            if (lookupValid && hit && state == idle && victim[lookupSet] == hitWay) begin
                victim[lookupSet] <= victim[lookupSet] + wayBits'(1);
            end

            case (state)
                flushWait: begin
                    if (!fillBusy) begin
                        state <= idle;
                    end
                end
                idle: begin
                    if (missStart) begin
                        validBits[lookupSet][victim[lookupSet]] <= 1'b0;
                        fillCmd <= FILL_LINE;
                        state <= loadRequest;
                    end
                end
                loadRequest: begin
                    if (fillBusy) begin   // controller has taken the command.
                        fillCmd <= FILL_NONE;
                        state <= loadActive;
                    end
                end
                loadActive: begin
                    if (!fillBusy) begin
                        validBits[loadSet][loadWay] <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // the new tag goes in at once, the way only turns valid after the fill.
    always_ff @(posedge clk) begin
        if (missStart) begin
            tagMem[lookupSet][victim[lookupSet]] <= lookupTag;
            loadSet <= lookupSet;
            loadWay <= victim[lookupSet];
            fillSramAddr <= {victim[lookupSet], lookupSet, {wordSelBits{1'b0}}};
            fillExtAddr <= {lookupPc[31:lineBytesLog], {wordSelBits{1'b0}}};
        end
    end

endmodule

// ==== hdl/lineFillCtrl.sv ====
`timescale 1ns/10ps

module lineFillCtrl (
    input  logic                                  clk,
    input  logic                                  rst,
    input  icachePkg::fillCmd_t                   fillCmd,
    input  logic [icachePkg::sramAddrBits-1:0]    fillSramAddr,
    input  logic [icachePkg::extAddrBits-1:0]     fillExtAddr,
    output logic                                  fillBusy,
    output logic                                  memReqValid,
    input  logic                                  memReqReady,
    output logic [icachePkg::extAddrBits-1:0]     memReqAddr,
    input  logic                                  memRespValid,
    input  logic [31:0]                           memRespData,
    output logic                                  wrEn,
    output logic [icachePkg::sramAddrBits-1:0]    wrAddr,
    output logic [31:0]                           wrData
);
    import icachePkg::*;

    logic [sramAddrBits-1:0] sramBase;
    logic [extAddrBits-1:0]  extBase;
    logic [wordSelBits:0]    reqCount;   // one bit wider so it can reach wordsPerLine.
    logic [wordSelBits-1:0]  respCount;
    logic                    fillStart;
    logic                    lastResp;

    assign fillStart = !fillBusy && (fillCmd == FILL_LINE);

    ////////////////////////////////////////
    // request and write channels
    ////////////////////////////////////////

    // requests run ahead of responses until all words of the line are asked for.
    assign memReqValid = fillBusy && (reqCount != (wordSelBits + 1)'(wordsPerLine));
    assign memReqAddr = extBase + extAddrBits'(reqCount[wordSelBits-1:0]);

    // responses come back in order, so a count is enough to place them.
    assign wrEn = fillBusy && memRespValid;
    assign wrAddr = sramBase + sramAddrBits'(respCount);
    assign wrData = memRespData;

    assign lastResp = wrEn && (respCount == wordSelBits'(wordsPerLine - 1));

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fillBusy <= 1'b0;
            reqCount <= '0;
            respCount <= '0;
        end else if (fillStart) begin
            fillBusy <= 1'b1;
            reqCount <= '0;
            respCount <= '0;
        end else if (fillBusy) begin
            if (memReqValid && memReqReady) begin
                reqCount <= reqCount + 1'b1;
            end
            if (wrEn) begin
                respCount <= respCount + 1'b1;
            end
            if (lastResp) begin
                fillBusy <= 1'b0;   // drops in the cycle after the last write.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fillStart) begin
            sramBase <= fillSramAddr;
            extBase <= fillExtAddr;
        end
    end

endmodule

// ==== hdl/icacheTop.sv ====
`timescale 1ns/10ps

module icacheTop (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fetchValid,
    input  logic [31:0]                           fetchPc,
    output logic                                  fetchReady,
    output logic [31:0]                           fetchData,
    output logic                                  fetchDataValid,
    output logic                                  memReqValid,
    input  logic                                  memReqReady,
    output logic [icachePkg::extAddrBits-1:0]     memReqAddr,
    input  logic                                  memRespValid,
    input  logic [31:0]                           memRespData
);
    import icachePkg::*;

    fillCmd_t                fillCmd;
    logic [sramAddrBits-1:0] fillSramAddr;
    logic [extAddrBits-1:0]  fillExtAddr;
    logic                    fillBusy;

    logic                    stall;
    logic                    accept;
    logic [sramAddrBits-1:0] rdAddr;
    logic                    wrEn;
    logic [sramAddrBits-1:0] wrAddr;
    logic [31:0]             wrData;

    assign fetchReady = !stall;
    assign accept = fetchValid && fetchReady;

    // valid lines up with the registered RAM read.
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDataValid <= 1'b0;
        end else begin
            fetchDataValid <= accept;
        end
    end

    icacheTags i_icacheTags (
        .clk          (clk),
        .rst          (rst),
        .lookupValid  (fetchValid),
        .lookupPc     (fetchPc),
        .lookupAddr   (rdAddr),
        .stall        (stall),
        .fillCmd      (fillCmd),
        .fillSramAddr (fillSramAddr),
        .fillExtAddr  (fillExtAddr),
        .fillBusy     (fillBusy)
    );

    lineFillCtrl i_lineFillCtrl (
        .clk          (clk),
        .rst          (rst),
        .fillCmd      (fillCmd),
        .fillSramAddr (fillSramAddr),
        .fillExtAddr  (fillExtAddr),
        .fillBusy     (fillBusy),
        .memReqValid  (memReqValid),
        .memReqReady  (memReqReady),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespData  (memRespData),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData)
    );

    icacheData i_icacheData (
        .clk    (clk),
        .rdEn   (accept),
        .rdAddr (rdAddr),
        .rdData (fetchData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

endmodule

// ==== testbench/extMemModel.sv ====
`timescale 1ns/10ps

module extMemModel #(
    parameter logic [31:0] dataKey = 32'h0
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  memReqValid,
    output logic                                  memReqReady,
    input  logic [icachePkg::extAddrBits-1:0]     memReqAddr,
    output logic                                  memRespValid,
    output logic [31:0]                           memRespData
);
    import icachePkg::*;

    logic [extAddrBits-1:0] addrQ [$];   // accepted requests, oldest first.
    int unsigned            dueQ [$];
    int unsigned            cycle;

    initial begin
        memReqReady = 1'b0;
        memRespValid = 1'b0;
        memRespData = '0;
        cycle = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            addrQ.delete();
            dueQ.delete();
            cycle = 0;
            memReqReady <= 1'b0;
            memRespValid <= 1'b0;
            memRespData <= '0;
        end else begin
            // the oldest request answers once its delay has run out.
            if (addrQ.size() > 0 && dueQ[0] <= cycle) begin
                memRespValid <= 1'b1;
                memRespData <= {2'b00, addrQ[0]} ^ dataKey;
                void'(addrQ.pop_front());
                void'(dueQ.pop_front());
            end else begin
                memRespValid <= 1'b0;
            end
            if (memReqValid && memReqReady) begin
                addrQ.push_back(memReqAddr);
                dueQ.push_back(cycle + 1 + ($urandom % 4));   // one to four cycles later.
            end
            memReqReady <= ($urandom % 4) != 0;
            cycle = cycle + 1;
        end
    end

endmodule

// ==== testbench/icacheTb.sv ====
`timescale 1ns/10ps

module icacheTb;
    import icachePkg::*;

    localparam int unsigned randSeed = 32'hc2bfd96e;
    localparam logic [31:0] dataKey = 32'h5a3c_96e1;   // memory word = word address ^ key.
    localparam int cycleLimit = 20000;
    localparam int randomFetches = 250;

    logic                   clk;
    logic                   rst;
    logic                   fetchValid;
    logic [31:0]            fetchPc;
    logic                   fetchReady;
    logic [31:0]            fetchData;
    logic                   fetchDataValid;
    logic                   memReqValid;
    logic                   memReqReady;
    logic [extAddrBits-1:0] memReqAddr;
    logic                   memRespValid;
    logic [31:0]            memRespData;

    int checkCount;
    int errorCount;
    int cycleCount;
    int fetchCount;

    // reference cache state.
    logic [tagBits-1:0] refTag [numSets][numWays];
    logic               refValid [numSets][numWays];
    int                 refVictim [numSets];

    logic [extAddrBits-1:0] reqSeen [$];
    logic                   acceptPrev;
    logic [31:0]            expectPrev;
    logic                   reqPendPrev;
    logic [extAddrBits-1:0] reqAddrPrev;

    icacheTop i_icacheTop (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchPc        (fetchPc),
        .fetchReady     (fetchReady),
        .fetchData      (fetchData),
        .fetchDataValid (fetchDataValid),
        .memReqValid    (memReqValid),
        .memReqReady    (memReqReady),
        .memReqAddr     (memReqAddr),
        .memRespValid   (memRespValid),
        .memRespData    (memRespData)
    );

    extMemModel #(.dataKey(dataKey)) i_extMemModel (
        .clk          (clk),
        .rst          (rst),
        .memReqValid  (memReqValid),
        .memReqReady  (memReqReady),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespData  (memRespData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic expectTrue(input bit ok, input string msg);
        checkCount++;
        assert (ok) else begin
            errorCount++;
            $display("** Error @ %0t ns: %s", $time, msg);
        end
    endtask

    ////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////

    // each handshake is seen half a cycle before the edge that completes it.
    always @(negedge clk) begin
        if (rst) begin
            acceptPrev = 1'b0;
            reqPendPrev = 1'b0;
        end else begin
            if (fetchDataValid || acceptPrev) begin
                expectTrue(fetchDataValid == acceptPrev,
                    "fetchDataValid not one cycle after accept");
            end
            if (fetchDataValid && acceptPrev) begin
                expectTrue(fetchData == expectPrev,
                    $sformatf("fetch data %h, expected %h", fetchData, expectPrev));
            end
            if (reqPendPrev) begin
                expectTrue(memReqValid && memReqAddr == reqAddrPrev,
                    "memory request changed before it was accepted");
            end
            if (memReqValid && memReqReady) begin
                reqSeen.push_back(memReqAddr);
            end
            acceptPrev = fetchValid && fetchReady;
            expectPrev = {2'b00, fetchPc[31:2]} ^ dataKey;
            reqPendPrev = memReqValid && !memReqReady;
            reqAddrPrev = memReqAddr;
        end
    end

    // returns 1 on an expected miss and updates the reference as the cache would.
    function automatic bit modelFetch(input logic [31:0] pc);
        int                 setIdx;
        logic [tagBits-1:0] tag;
        int                 way;
        bit                 miss;
        setIdx = int'(pc[lineBytesLog +: setBits]);
        tag = pc[31 -: tagBits];
        way = -1;
        for (int w = 0; w < numWays; w++) begin
            if (refValid[setIdx][w] && refTag[setIdx][w] == tag) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            way = refVictim[setIdx];
            refTag[setIdx][way] = tag;
            refValid[setIdx][way] = 1'b1;
        end
        // the retried fetch hits, which moves the pointer off this way.
        if (refVictim[setIdx] == way) begin
            refVictim[setIdx] = (way + 1) % numWays;
        end
        return miss;
    endfunction

    task automatic doFetch(input logic [31:0] pc);
        bit expectMiss;
        int waits;
        expectMiss = modelFetch(pc);
        fetchValid <= 1'b1;
        fetchPc <= pc;
        waits = 0;
        @(posedge clk);
        while (!fetchReady) begin
            waits++;
            @(posedge clk);
        end
        if (expectMiss) begin
            expectTrue(waits > 0, $sformatf("miss at %h accepted without a stall", pc));
            expectTrue(reqSeen.size() == wordsPerLine,
                $sformatf("miss at %h sent %0d memory requests", pc, reqSeen.size()));
            for (int i = 0; i < reqSeen.size() && i < wordsPerLine; i++) begin
                expectTrue(reqSeen[i] == {pc[31:lineBytesLog], wordSelBits'(i)},
                    $sformatf("fill request %0d went to %h", i, reqSeen[i]));
            end
        end else begin
            expectTrue(waits == 0, $sformatf("hit at %h was stalled", pc));
            expectTrue(reqSeen.size() == 0, $sformatf("hit at %h sent memory requests", pc));
        end
        reqSeen.delete();   // later requests count against the next fetch.
        fetchCount++;
    endtask

    task automatic idleCycles(input int n);
        fetchValid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] lineA;
        logic [31:0] lineB;
        logic [31:0] lineC;
        int unsigned lineIdx;
        int unsigned word;
        void'($urandom(randSeed));
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        checkCount = 0;
        errorCount = 0;
        fetchCount = 0;
        for (int s = 0; s < numSets; s++) begin
            refVictim[s] = 0;
            for (int w = 0; w < numWays; w++) begin
                refValid[s][w] = 1'b0;
                refTag[s][w] = '0;
            end
        end
        lineA = 32'h0000_1000;   // three lines that share set 0.
        lineB = 32'h0000_2000;
        lineC = 32'h0000_3000;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        expectTrue(!fetchReady, "fetchReady high in the flush cycle after reset");
        repeat (4) begin
            expectTrue(!fetchDataValid && !memReqValid, "activity before the first fetch");
            @(posedge clk);
        end

        for (int i = 0; i < wordsPerLine; i++) begin
            doFetch(lineA + 32'(i * 4));
        end
        doFetch(lineA);
        idleCycles(2);

        doFetch(lineB);
        for (int i = 0; i < 12; i++) begin
            doFetch(((i % 2) == 0 ? lineA : lineB) + 32'((i % 4) * 4));
        end
        idleCycles(1);

        doFetch(lineC);   // evicts whichever way the pointer names.
        doFetch(lineA);
        doFetch(lineB);
        doFetch(lineC + 32'h4);
        doFetch(32'h0000_1010);
        idleCycles(2);

        for (int n = 0; n < randomFetches; n++) begin
            lineIdx = $urandom % 16;
            word = $urandom % 4;
            doFetch(32'h0000_4000 + 32'(lineIdx * 16) + 32'(word * 4));
            if (($urandom % 8) == 0) begin
                idleCycles(int'($urandom % 3) + 1);
            end
        end
        idleCycles(4);

        $display("Fetches: %0d, checks: %0d, errors: %0d", fetchCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/icachePkg.sv
hdl/icacheData.sv
hdl/icacheTags.sv
hdl/lineFillCtrl.sv
hdl/icacheTop.sv
testbench/extMemModel.sv
testbench/icacheTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = icacheTb
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSTEXT = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASSTEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
